// ==== test/cache_stimulus.txt ====
// columns: request byte address, idle cycles before each refill beat, refill expected
// all hex; set 0 lines are 00000000, 00000800 and 00001000
00000000 0 1
00000008 0 0
00000018 0 0
00000800 1 1
00000010 0 0
00000808 0 0
00001000 2 1
00000818 0 0
00000000 0 1
00001008 0 1
00000808 3 1
00001010 0 0
00000810 0 0
00001018 0 0
00000800 0 0
00000020 1 1
00000028 0 0
00000030 0 0
00000038 0 0
0000a040 2 1
0000a048 0 0
12345660 4 1
12345678 0 0
0000a050 0 0
00000010 0 1
00001000 0 1
00000808 0 1

// ==== all.f ====
+incdir+common
common/cachePkg.sv
cache/cacheCtrl.sv
cache/cacheWay.sv
cache/hitMerge.sv
rtl/cacheTop.sv
test/cacheTop_assertions.sv
test/cacheTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cacheTb \
  -Mdir obj_dir -o cacheSim > build.log 2>&1 &&
  ./obj_dir/cacheSim > sim.log 2>&1 ||
  { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^NO ERRORS$" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }

// ==== test/cacheTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheTb
  import cachePkg::*;
();

  localparam int maxReq = 64;

  logic  clk;
  logic  rst_n;
  logic  valid_i;
  addr_t addr_i;
  logic  rdDataValid_i;
  logic  rdLast_i;
  word_t rdData_i;
  logic  addr_ok_o;
  logic  data_ok_o;
  word_t rd_data_o;
  logic  cacheRdValid_o;
  addr_t cacheAddr_o;

  // three hex words per request for address, stall and refill flag
  logic [31:0] stimMem [3*maxReq];
  int          acceptCycle [maxReq];
  int          numReq;
  int          reqIdx;
  int          respIdx;
  int          refillsSeen;
  int          cycleCnt;
  int          valueErrs;
  int          otherErrs;
  bit          stimLoaded;
  bit          rdValidPrev;

  cacheTop i_cacheTop (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .rdDataValid_i  (rdDataValid_i),
    .rdLast_i       (rdLast_i),
    .rdData_i       (rdData_i),
    .addr_ok_o      (addr_ok_o),
    .data_ok_o      (data_ok_o),
    .rd_data_o      (rd_data_o),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o)
  );

  bind cacheTop cacheTop_assertions i_cacheTopAssertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr_ok_o      (addr_ok_o),
    .data_ok_o      (data_ok_o),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o)
  );

  function automatic addr_t stimAddr(int i);
    return stimMem[3*i];
  endfunction

  function automatic int stimStall(int i);
    return int'(stimMem[3*i+1]);
  endfunction

  function automatic bit stimRefill(int i);
    return stimMem[3*i+2][0];
  endfunction

  // memory word holds the inverted word address in its upper half
  function automatic word_t memWord(addr_t a);
    addr_t w;
    w = a & 32'hffff_fff8;
    return {~w, w};
  endfunction

  task automatic checkWord(string name, word_t got, word_t exp);
    if (got !== exp) begin
      valueErrs++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkAddr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      valueErrs++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkFlag(string name, bit got, bit exp);
    if (got !== exp) begin
      valueErrs++;
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkCount(string name, int got, int exp);
    if (got != exp) begin
      valueErrs++;
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic reportFailure(string what);
    otherErrs++;
    $display("FAILURE at %0t ns: %s", $time, what);
  endtask

  // check one response against the oldest accepted request
  task automatic checkResponse();
    if (respIdx >= reqIdx) begin
      reportFailure("data_ok_o pulsed with no request outstanding");
    end else begin
      checkWord("rd_data_o", rd_data_o, memWord(stimAddr(respIdx)));
      if (stimRefill(respIdx) && refillsSeen == 0) begin
        reportFailure($sformatf("read of %h finished without the expected refill",
                                stimAddr(respIdx)));
      end else begin
        checkCount("refill count", refillsSeen, int'(stimRefill(respIdx)));
      end
      if (!stimRefill(respIdx)) begin
        checkCount("data_ok_o latency", cycleCnt - acceptCycle[respIdx], 2);
        // a hit right after a hit is taken in that hit's compare cycle
        if (respIdx > 0 && !stimRefill(respIdx - 1)) begin
          checkCount("accept spacing", acceptCycle[respIdx] - acceptCycle[respIdx - 1], 1);
        end
      end
      refillsSeen = 0;
      respIdx++;
    end
  endtask

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
  end

  // monitor samples mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (cacheRdValid_o && !rdValidPrev) begin
        refillsSeen++;
        checkAddr("cacheAddr_o", cacheAddr_o, stimAddr(respIdx) & 32'hffff_ffe0);
      end
      rdValidPrev = cacheRdValid_o;
      if (data_ok_o) begin
        checkResponse();
      end
    end
  end

  // memory answers a line request with four beats and stalls before each
  initial begin : memoryModel
    int    stall;
    addr_t lineAddr;
    forever begin
      @(negedge clk);
      if (rst_n && cacheRdValid_o) begin
        stall = stimStall(respIdx);
        lineAddr = cacheAddr_o;
        for (int k = 0; k < 4; k++) begin
          repeat (stall) begin
            @(posedge clk);
            #2;
            rdDataValid_i = 1'b0;
            rdLast_i = 1'b0;
          end
          @(posedge clk);
          #2;
          rdDataValid_i = 1'b1;
          rdData_i = memWord(lineAddr + addr_t'(8 * k));
          rdLast_i = (k == 3);
        end
        @(posedge clk);
        #2;
        rdDataValid_i = 1'b0;
        rdLast_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (stimLoaded);
    limit = 100;
    for (int i = 0; i < numReq; i++) begin
      limit += 20 + 4 * (stimStall(i) + 1);
    end
    repeat (limit) @(posedge clk);
    $display("FAILURE: watchdog stopped the run after %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : mainFlow
    int gap;
    int waitCnt;
    clk = 1'b0;
    rst_n = 1'b0;
    valid_i = 1'b0;
    addr_i = '0;
    rdDataValid_i = 1'b0;
    rdLast_i = 1'b0;
    rdData_i = '0;
    cycleCnt = 0;
    reqIdx = 0;
    respIdx = 0;
    refillsSeen = 0;
    valueErrs = 0;
    otherErrs = 0;
    rdValidPrev = 1'b0;
    gap = $urandom(32'h9efd_bcbd);
    // all-ones address marks the end of the file
    for (int i = 0; i < 3 * maxReq; i++) begin
      stimMem[i] = 32'hffff_ffff;
    end
    $readmemh("test/cache_stimulus.txt", stimMem);
    numReq = 0;
    while (numReq < maxReq && stimMem[3*numReq] != 32'hffff_ffff) begin
      numReq++;
    end
    stimLoaded = 1'b1;
    if (numReq == 0) begin
      reportFailure("stimulus file holds no requests");
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      checkFlag("addr_ok_o", addr_ok_o, 1'b0);
      checkFlag("data_ok_o", data_ok_o, 1'b0);
      checkFlag("cacheRdValid_o", cacheRdValid_o, 1'b0);
    end
    @(posedge clk);
    #2;
    for (int i = 0; i < numReq; i++) begin
      // idle gap only ahead of misses so hits keep streaming
      if (stimRefill(i)) begin
        gap = $urandom % 4;
        valid_i = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #2;
        end
      end
      valid_i = 1'b1;
      addr_i = stimAddr(i);
      @(negedge clk);
      while (!addr_ok_o) begin
        @(negedge clk);
      end
      acceptCycle[i] = cycleCnt;
      reqIdx = i + 1;
      @(posedge clk);
      #2;
    end
    valid_i = 1'b0;
    waitCnt = 0;
    while (respIdx < numReq && waitCnt < 200) begin
      @(negedge clk);
      waitCnt++;
    end
    if (respIdx < numReq) begin
      reportFailure($sformatf("%0d requests never saw data_ok_o", numReq - respIdx));
    end
    $display("checks finished: %0d value errors, %0d other errors", valueErrs, otherErrs);
    if (valueErrs + otherErrs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/cacheTop_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheTop_assertions
  import cachePkg::*;
(
  input wire        clk,
  input wire        rst_n,
  input wire        addr_ok_o,
  input wire        data_ok_o,
  input wire        cacheRdValid_o,
  input wire addr_t cacheAddr_o
);

  // line address held for the whole refill
  addrSteady: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o |=> !cacheRdValid_o || $stable(cacheAddr_o))
    else $error("cacheAddr_o changed during a refill");

  // back-to-back responses need a request accepted during the first compare
  respPaced: assert property (@(posedge clk) disable iff (!rst_n)
    data_ok_o && $past(data_ok_o) |-> $past(addr_ok_o, 2))
    else $error("data_ok_o held two cycles without a new acceptance");

  lineAligned: assert property (@(posedge clk) disable iff (!rst_n)
    cacheAddr_o[OFFSET_W-1:0] == '0)
    else $error("cacheAddr_o is not line aligned");

endmodule

`default_nettype wire

// ==== rtl/cacheTop.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_consts.svh"

module cacheTop
  import cachePkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         valid_i,
  input  wire addr_t  addr_i,
  input  wire         rdDataValid_i,
  input  wire         rdLast_i,
  input  wire word_t  rdData_i,
  output logic        addr_ok_o,
  output logic        data_ok_o,
  output word_t       rd_data_o,
  output logic        cacheRdValid_o,
  output addr_t       cacheAddr_o
);

  logic                              lookupEn;
  logic                              compareEn;
  index_t                            index;
  tag_t                              tag;
  beat_t                             wordSel;
  logic [`WAYS-1:0]                  refillWe;
  beat_t                             refillBeat;
  word_t                             refillData;
  logic [`WAYS-1:0]                  refillDone;
  logic                              hit;
  logic [WAY_W-1:0]                  hitWay;
  logic [`WAYS-1:0]                  wayHit;
  word_t [`WAYS-1:0][`LINE_BEATS-1:0] wayLine;

  cacheCtrl i_cacheCtrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .hit_i          (hit),
    .hitWay_i       (hitWay),
    .rdDataValid_i  (rdDataValid_i),
    .rdLast_i       (rdLast_i),
    .rdData_i       (rdData_i),
    .addr_ok_o      (addr_ok_o),
    .lookupEn_o     (lookupEn),
    .compareEn_o    (compareEn),
    .index_o        (index),
    .tag_o          (tag),
    .wordSel_o      (wordSel),
    .refillWe_o     (refillWe),
    .refillBeat_o   (refillBeat),
    .refillData_o   (refillData),
    .refillDone_o   (refillDone),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o)
  );

  for (genvar w = 0; w < `WAYS; w++) begin : gWay
    cacheWay i_cacheWay (
      .clk          (clk),
      .rst_n        (rst_n),
      .lookupEn_i   (lookupEn),
      .index_i      (index),
      .tag_i        (tag),
      .refillWe_i   (refillWe[w]),
      .refillBeat_i (refillBeat),
      .refillData_i (refillData),
      .refillDone_i (refillDone[w]),
      .wayHit_o     (wayHit[w]),
      .wayLine_o    (wayLine[w])
    );
  end

  hitMerge i_hitMerge (
    .clk         (clk),
    .rst_n       (rst_n),
    .wayHit_i    (wayHit),
    .wayLine_i   (wayLine),
    .wordSel_i   (wordSel),
    .compareEn_i (compareEn),
    .hit_o       (hit),
    .hitWay_o    (hitWay),
    .rd_data_o   (rd_data_o),
    .data_ok_o   (data_ok_o)
  );

endmodule

`default_nettype wire

// ==== cache/hitMerge.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_consts.svh"

module hitMerge
  import cachePkg::*;
(
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire [`WAYS-1:0]                       wayHit_i,
  input  wire word_t [`WAYS-1:0][`LINE_BEATS-1:0] wayLine_i,
  input  wire beat_t                            wordSel_i,
  input  wire                                   compareEn_i,
  output logic                                  hit_o,
  output logic [WAY_W-1:0]                      hitWay_o,
  output word_t                                 rd_data_o,
  output logic                                  data_ok_o
);

  assign hit_o = |wayHit_i;

  // at most one way hits, so a plain encoder is enough
  always_comb begin
    hitWay_o = '0;
    for (int w = 0; w < `WAYS; w++) begin
      if (wayHit_i[w]) begin
        hitWay_o = WAY_W'(w);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (compareEn_i && hit_o) begin
      rd_data_o <= wayLine_i[hitWay_o][wordSel_i];
    end
  end

  // one pulse per answered request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_ok_o <= 1'b0;
    end else begin
      data_ok_o <= compareEn_i && hit_o;
    end
  end

endmodule

`default_nettype wire

// ==== cache/cacheWay.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_consts.svh"

module cacheWay
  import cachePkg::*;
(
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           lookupEn_i,
  input  wire index_t                   index_i,
  input  wire tag_t                     tag_i,
  input  wire                           refillWe_i,
  input  wire beat_t                    refillBeat_i,
  input  wire word_t                    refillData_i,
  input  wire                           refillDone_i,
  output logic                          wayHit_o,
  output word_t [`LINE_BEATS-1:0]       wayLine_o
);

  tag_t                    tagArr  [`SETS];
  word_t [`LINE_BEATS-1:0] lineArr [`SETS];
  logic [`SETS-1:0]        validArr;
  tag_t                    tagQ;
  logic                    validQ;

  // line data written one beat at a time during refill
  always_ff @(posedge clk) begin
    if (refillWe_i) begin
      lineArr[index_i][refillBeat_i] <= refillData_i;
    end
    if (refillDone_i) begin
      tagArr[index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
    end else if (refillDone_i) begin
      validArr[index_i] <= 1'b1;
    end
  end

  // registered lookup, compared in the following cycle
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagQ      <= tagArr[index_i];
      wayLine_o <= lineArr[index_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
    end else if (lookupEn_i) begin
      validQ <= validArr[index_i];
    end
  end

  // tag_i is the latched request tag during compare
  assign wayHit_o = validQ && (tagQ == tag_i);

endmodule

`default_nettype wire

// ==== cache/cacheCtrl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_consts.svh"

module cacheCtrl
  import cachePkg::*;
(
  input  wire                clk,
  input  wire                rst_n,
  input  wire                valid_i,
  input  wire addr_t         addr_i,
  input  wire                hit_i,
  input  wire [WAY_W-1:0]    hitWay_i,
  input  wire                rdDataValid_i,
  input  wire                rdLast_i,
  input  wire word_t         rdData_i,
  output logic               addr_ok_o,
  output logic               lookupEn_o,
  output logic               compareEn_o,
  output index_t             index_o,
  output tag_t               tag_o,
  output beat_t              wordSel_o,
  output logic [`WAYS-1:0]   refillWe_o,
  output beat_t              refillBeat_o,
  output word_t              refillData_o,
  output logic [`WAYS-1:0]   refillDone_o,
  output logic               cacheRdValid_o,
  output addr_t              cacheAddr_o
);

  cacheState_e      state;
  cacheState_e      nextState;
  addr_t            reqAddr;
  index_t           reqIndex;
  logic [`SETS-1:0] lru;
  logic [WAY_W-1:0] victim;
  beat_t            beatCnt;
  logic             beatIn;

  assign reqIndex = reqAddr[OFFSET_W +: INDEX_W];

  // lru bit names the way to evict next
  assign victim = lru[reqIndex];

  // accept from idle, or alongside a hit so hits stream
  assign addr_ok_o   = valid_i && ((state == IDLE) || ((state == COMPARE) && hit_i));
  assign compareEn_o = (state == COMPARE);

  // arrays read on acceptance and once more after a refill
  assign lookupEn_o = addr_ok_o || (state == RELOOK);
  assign index_o    = addr_ok_o ? addr_i[OFFSET_W +: INDEX_W] : reqIndex;
  assign tag_o      = reqAddr[`ADDR_W-1 -: TAG_W];
  assign wordSel_o  = reqAddr[OFFSET_W-1 -: $bits(beat_t)];

  // line fetch stays up from MISS until the last beat
  assign cacheRdValid_o = (state == MISS) || (state == REFILL);
  assign cacheAddr_o    = {reqAddr[`ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign beatIn         = cacheRdValid_o && rdDataValid_i;

  assign refillBeat_o = beatCnt;
  assign refillData_o = rdData_i;

  // steer incoming beats into the victim way
  always_comb begin
    refillWe_o   = '0;
    refillDone_o = '0;
    if (beatIn) begin
      refillWe_o[victim]   = 1'b1;
      refillDone_o[victim] = rdLast_i;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (valid_i) begin
          nextState = COMPARE;
        end
      end
      COMPARE: begin
        if (!hit_i) begin
          nextState = MISS;
        end else if (!valid_i) begin
          nextState = IDLE;
        end
      end
      MISS, REFILL: begin
        if (beatIn && rdLast_i) begin
          nextState = RELOOK;
        end else begin
          nextState = REFILL;
        end
      end
      RELOOK: begin
        nextState = COMPARE;
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqAddr <= '0;
    end else if (addr_ok_o) begin
      reqAddr <= addr_i;
    end
  end

  // hit makes the other way the victim; a fill does the same
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lru <= '0;
    end else if (compareEn_o && hit_i) begin
      lru[reqIndex] <= ~hitWay_i;
    end else if (beatIn && rdLast_i) begin
      lru[reqIndex] <= ~victim;
    end
  end

  // beats arrive word 0 first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (compareEn_o) begin
      beatCnt <= '0;
    end else if (beatIn) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== common/cachePkg.sv ====
`default_nettype none
`include "cache_consts.svh"

package cachePkg;

  // address split into offset, index and tag
  localparam int OFFSET_W = $clog2(`LINE_BEATS * `XLEN / 8);
  localparam int INDEX_W  = $clog2(`SETS);
  localparam int TAG_W    = `ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAY_W    = $clog2(`WAYS);

  typedef logic [`ADDR_W-1:0]            addr_t;
  typedef logic [`XLEN-1:0]              word_t;
  typedef logic [TAG_W-1:0]              tag_t;
  typedef logic [INDEX_W-1:0]            index_t;
  typedef logic [$clog2(`LINE_BEATS)-1:0] beat_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    COMPARE,
    MISS,
    REFILL,
    RELOOK
  } cacheState_e;

endpackage

`default_nettype wire

// ==== common/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// pipeline byte address width
`define ADDR_W 32

// one data word
`define XLEN 64

// sets per way
`define SETS 64

// associativity
`define WAYS 2

// words per 32-byte line
`define LINE_BEATS 4

`endif
